// ==== rtl/evq_pkg.sv ====
package evq_pkg;

    // bus geometry
    localparam int MMR_ADDR_W = 8;
    localparam int MMR_DATA_W = 32;

    // event queue geometry
    localparam int EVENT_W    = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = 5;     // holds 0..FIFO_DEPTH
    localparam int DROP_W     = 16;

    typedef logic [MMR_ADDR_W-1:0] addr_t;
    typedef logic [MMR_DATA_W-1:0] data_t;
    typedef logic [EVENT_W-1:0]    event_t;
    typedef logic [LEVEL_W-1:0]    level_t;
    typedef logic [DROP_W-1:0]     drop_t;

    // register map
    localparam addr_t REG_SR   = 8'h00;
    localparam addr_t REG_CR   = 8'h04;
    localparam addr_t REG_CR_S = 8'h08;   // set alias
    localparam addr_t REG_CR_C = 8'h0C;   // clear alias
    localparam addr_t REG_DATA = 8'h14;   // read pops one event
    localparam addr_t REG_DROP = 8'h18;   // any write clears

    // control register layout
    localparam int CR_W      = 2;
    localparam int CR_EN_BIT = 0;

    // status and data word layout
    localparam int SR_EMPTY_BIT   = 0;
    localparam int SR_FULL_BIT    = 1;
    localparam int SR_LEVEL_LSB   = 8;
    localparam int DATA_VALID_BIT = 31;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

endpackage

// ==== rtl/event_source.sv ====
`timescale 1ns/1ps

module event_source
    import evq_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,

    input  logic   ev_strobe,
    input  event_t ev_code,

    input  logic   capture_en,
    input  logic   credit_return,
    input  logic   drop_clear,

    output logic   push,
    output event_t push_data,
    output drop_t  drop_count
);

    level_t credits;
    logic   has_credit;
    logic   admit;
    logic   drop;

    assign has_credit = (credits != '0);
    assign admit      = ev_strobe && capture_en && has_credit;
    assign drop       = ev_strobe && capture_en && !has_credit;

    // credit counter, one spent per admitted event
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credits <= level_t'(FIFO_DEPTH);
        end else begin
            case ({admit, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // none or both
            endcase
        end
    end

    // admitted event goes out the next cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            push <= 1'b0;
        end else begin
            push <= admit;
        end
    end

    always_ff @(posedge aclk) begin
        if (admit) begin
            push_data <= ev_code;
        end
    end

    // saturating drop counter
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            drop_count <= '0;
        end else if (drop_clear) begin
            drop_count <= '0;
        end else if (drop && !(&drop_count)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// ==== rtl/event_buffer.sv ====
`timescale 1ns/1ps

module event_buffer
    import evq_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,

    input  logic   push,
    input  event_t push_data,

    input  logic   pop,
    output event_t pop_data,

    output level_t level,
    output logic   empty,
    output logic   full,
    output logic   credit_return
);

    event_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    assign empty = (level == '0);
    assign full  = (level == level_t'(FIFO_DEPTH));

    // storage array, no reset
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // registered read port
    always_ff @(posedge aclk) begin
        if (pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    // pointers wrap on power-of-two depth
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            level <= '0;
        end else begin
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // one credit back per popped entry, aligned with pop_data
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

// ==== rtl/event_regs.sv ====
`timescale 1ns/1ps

module event_regs
    import evq_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    // read address and data channels
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output logic       rvalid,
    input  logic       rready,
    output data_t      rdata,
    output logic [1:0] rresp,

    // write address, data and response channels
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,

    // buffer side
    input  event_t     pop_data,
    input  level_t     level,
    input  logic       empty,
    input  logic       full,
    output logic       pop,

    // source side
    input  drop_t      drop_count,
    output logic       capture_en,
    output logic       drop_clear
);

    rd_state_t         rd_state;
    addr_t             rd_addr;
    addr_t             wr_addr;
    data_t             wr_data;
    logic              aw_done;
    logic              w_done;
    logic [CR_W-1:0]   cr;
    data_t             sr_word;
    data_t             rd_word;

    assign rresp      = 2'b00;   // always OKAY
    assign bresp      = 2'b00;
    assign capture_en = cr[CR_EN_BIT];

    always_comb begin
        sr_word                                  = '0;
        sr_word[SR_EMPTY_BIT]                    = empty;
        sr_word[SR_FULL_BIT]                     = full;
        sr_word[SR_LEVEL_LSB +: LEVEL_W]         = level;
    end

    // read mux for everything except a DATA pop
    always_comb begin
        case (rd_addr)
            REG_SR:   rd_word = sr_word;
            REG_CR:   rd_word = data_t'(cr);
            REG_DROP: rd_word = data_t'(drop_count);
            default:  rd_word = '0;      // unmapped, or DATA on an empty queue
        endcase
    end

    // read channel FSM
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_state <= RD_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            pop      <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        arready  <= 1'b1;
                        rd_state <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    arready <= 1'b0;
                    if (rd_addr == REG_DATA && !empty) begin
                        pop      <= 1'b1;
                        rd_state <= RD_WAIT;
                    end else begin
                        rvalid   <= 1'b1;
                        rd_state <= RD_RESP;
                    end
                end
                RD_WAIT: begin
                    // pop high on first pass, pop_data valid on second
                    if (pop) begin
                        pop <= 1'b0;
                    end else begin
                        rvalid   <= 1'b1;
                        rd_state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // read address and response data, payload only
    always_ff @(posedge aclk) begin
        if (rd_state == RD_IDLE && arvalid) begin
            rd_addr <= araddr;
        end
        if (rd_state == RD_FETCH && !(rd_addr == REG_DATA && !empty)) begin
            rdata <= rd_word;
        end else if (rd_state == RD_WAIT && !pop) begin
            rdata                 <= data_t'(pop_data);
            rdata[DATA_VALID_BIT] <= 1'b1;         // marks a real event
        end
    end

    // write channels, each ready pulses once per transaction
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            bvalid     <= 1'b0;
            cr         <= '0;
            drop_clear <= 1'b0;
        end else begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            drop_clear <= 1'b0;

            if (awvalid && !aw_done && !awready) begin
                awready <= 1'b1;
                aw_done <= 1'b1;
            end
            if (wvalid && !w_done && !wready) begin
                wready <= 1'b1;
                w_done <= 1'b1;
            end

            if (aw_done && w_done && !bvalid) begin
                bvalid <= 1'b1;
                case (wr_addr)
                    REG_CR:   cr         <= wr_data[CR_W-1:0];
                    REG_CR_S: cr         <= cr | wr_data[CR_W-1:0];
                    REG_CR_C: cr         <= cr & ~wr_data[CR_W-1:0];
                    REG_DROP: drop_clear <= 1'b1;
                    default:  ;                    // ignored
                endcase
            end

            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    // captured write address and data
    always_ff @(posedge aclk) begin
        if (awvalid && !aw_done && !awready) begin
            wr_addr <= awaddr;
        end
        if (wvalid && !w_done && !wready) begin
            wr_data <= wdata;
        end
    end

endmodule

// ==== rtl/event_capture_top.sv ====
`timescale 1ns/1ps

module event_capture_top
    import evq_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    // event input
    input  logic       ev_strobe,
    input  event_t     ev_code,

    // AXI4-lite slave
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output logic       rvalid,
    input  logic       rready,
    output data_t      rdata,
    output logic [1:0] rresp,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp
);

    logic   push;
    event_t push_data;
    logic   credit_return;
    logic   pop;
    event_t pop_data;
    level_t level;
    logic   empty;
    logic   full;
    logic   capture_en;
    logic   drop_clear;
    drop_t  drop_count;

    event_source src0 (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ev_strobe     (ev_strobe),
        .ev_code       (ev_code),
        .capture_en    (capture_en),
        .credit_return (credit_return),
        .drop_clear    (drop_clear),
        .push          (push),
        .push_data     (push_data),
        .drop_count    (drop_count)
    );

    event_buffer buf0 (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .pop_data      (pop_data),
        .level         (level),
        .empty         (empty),
        .full          (full),
        .credit_return (credit_return)
    );

    event_regs regs0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .pop_data   (pop_data),
        .level      (level),
        .empty      (empty),
        .full       (full),
        .pop        (pop),
        .drop_count (drop_count),
        .capture_en (capture_en),
        .drop_clear (drop_clear)
    );

endmodule

// ==== verif/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

task automatic check_eq(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("Mismatch at time %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "wrong value seen on %s", name);
    end
endtask

// hold is the number of cycles rready stays low once rvalid is up
task automatic axi_read(input addr_t addr, input int hold, output data_t data);
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    @(negedge aclk);                            // handshake on the edge just passed
    arvalid = 1'b0;
    while (!rvalid) @(negedge aclk);
    data = rdata;
    check_eq("rresp", data_t'(rresp), '0);      // OKAY
    repeat (hold) begin
        @(negedge aclk);
        check_eq("rvalid", data_t'(rvalid), 32'd1);
        check_eq("rdata", rdata, data);         // must not move while stalled
    end
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
endtask

task automatic axi_write(input addr_t addr, input data_t data);
    logic aw_hs;
    logic w_hs;
    aw_hs   = 1'b0;
    w_hs    = 1'b0;
    @(negedge aclk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    // each valid drops one cycle after its ready was seen
    while (awvalid || wvalid) begin
        @(negedge aclk);
        if (aw_hs) awvalid = 1'b0;
        if (w_hs) wvalid = 1'b0;
        aw_hs = awvalid && awready;
        w_hs  = wvalid && wready;
    end
    while (!bvalid) @(negedge aclk);
    check_eq("bresp", data_t'(bresp), '0);      // OKAY
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
endtask

// drives one strobe and updates the expected queue by the credit rules
task automatic strobe_event(input event_t code);
    @(negedge aclk);
    ev_strobe = 1'b1;
    ev_code   = code;
    if (capture_on) begin
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(code);
        end else if (exp_drops != '1) begin
            exp_drops++;                        // no credit left
        end
    end
endtask

`endif

// ==== verif/tb_event_capture.sv ====
`timescale 1ns/1ps

module tb_event_capture
    import evq_pkg::*;
();

    localparam int MAX_CYCLES = 4000;

    logic       aclk;
    logic       aresetn;
    logic       ev_strobe;
    event_t     ev_code;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    logic       rvalid;
    logic       rready;
    data_t      rdata;
    logic [1:0] rresp;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;

    event_t     exp_q[$];                       // expected queue contents
    drop_t      exp_drops;
    logic       capture_on;
    int         cycles;

    event_capture_top dut0 (
        .aclk(aclk), .aresetn(aresetn), .ev_strobe(ev_strobe), .ev_code(ev_code),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rvalid(rvalid),
        .rready(rready), .rdata(rdata), .rresp(rresp), .awaddr(awaddr),
        .awvalid(awvalid), .awready(awready), .wdata(wdata), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready), .bresp(bresp)
    );

    `include "tb_axi_tasks.svh"

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
    end

    function automatic data_t status_word(input int n);
        data_t w;
        w       = '0;
        w[0]    = (n == 0);
        w[1]    = (n == FIFO_DEPTH);
        w[12:8] = level_t'(n);
        return w;
    endfunction

    function automatic data_t data_word(input event_t code);
        return {1'b1, 23'd0, code};
    endfunction

    task automatic read_expect(input addr_t addr, input data_t exp, input string name);
        data_t got;
        axi_read(addr, 0, got);
        check_eq(name, got, exp);
    endtask

    task automatic strobe_idle();
        @(negedge aclk);
        ev_strobe = 1'b0;
    endtask

    task automatic drain(input int n);
        event_t head;
        for (int i = 0; i < n; i++) begin
            head = exp_q.pop_front();
            read_expect(REG_DATA, data_word(head), "data");
        end
    endtask

    task automatic reset_idle_check();
        check_eq("arready", data_t'(arready), '0);
        check_eq("rvalid", data_t'(rvalid), '0);
        check_eq("awready", data_t'(awready), '0);
        check_eq("wready", data_t'(wready), '0);
        check_eq("bvalid", data_t'(bvalid), '0);
        read_expect(REG_SR, status_word(0), "sr");
        read_expect(REG_DROP, '0, "drop");
    endtask

    task automatic control_semantics();
        axi_write(REG_CR, 32'd2);
        read_expect(REG_CR, 32'd2, "cr");
        axi_write(REG_CR_S, 32'd1);
        read_expect(REG_CR, 32'd3, "cr after set");
        axi_write(REG_CR_C, 32'd2);
        read_expect(REG_CR, 32'd1, "cr after clear");
        axi_write(REG_CR_C, 32'd1);             // capture off again
        read_expect(REG_CR, 32'd0, "cr disabled");
        for (int i = 0; i < 4; i++) begin
            strobe_event(event_t'($urandom));
        end
        strobe_idle();
        read_expect(REG_SR, status_word(0), "sr disabled");
        read_expect(REG_DROP, '0, "drop disabled");
    endtask

    task automatic ordered_capture();
        axi_write(REG_CR_S, 32'd1);
        capture_on = 1'b1;
        for (int i = 0; i < 5; i++) begin
            strobe_event(event_t'($urandom));
        end
        strobe_idle();
        read_expect(REG_SR, status_word(5), "sr");
        drain(5);
        read_expect(REG_DATA, '0, "data empty");
    endtask

    task automatic credit_overflow();
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            strobe_event(event_t'($urandom));   // back to back
        end
        strobe_idle();
        read_expect(REG_SR, status_word(FIFO_DEPTH), "sr full");
        read_expect(REG_DROP, data_t'(exp_drops), "drop");
        drain(FIFO_DEPTH);
        // credits are back, so these get in
        strobe_event(event_t'($urandom));
        strobe_event(event_t'($urandom));
        strobe_idle();
        read_expect(REG_SR, status_word(2), "sr refill");
    endtask

    task automatic drop_clear_keeps_queue();
        axi_write(REG_DROP, 32'hFFFF_FFFF);
        exp_drops = '0;
        read_expect(REG_DROP, '0, "drop cleared");
        read_expect(REG_SR, status_word(exp_q.size()), "sr kept");
    endtask

    task automatic read_backpressure();
        data_t  got;
        event_t head;
        head = exp_q.pop_front();
        axi_read(REG_DATA, 6, got);
        check_eq("rdata stalled", got, data_word(head));
        drain(exp_q.size());
        read_expect(REG_SR, status_word(0), "sr drained");
    endtask

    initial begin
        void'($urandom(32'h2914_9dc4));
        aresetn    = 1'b0;
        ev_strobe  = 1'b0;
        ev_code    = '0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        capture_on = 1'b0;
        exp_drops  = '0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        reset_idle_check();
        control_semantics();
        ordered_capture();
        credit_overflow();
        drop_clear_keeps_queue();
        read_backpressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verif
rtl/evq_pkg.sv
rtl/event_source.sv
rtl/event_buffer.sv
rtl/event_regs.sv
rtl/event_capture_top.sv
verif/tb_event_capture.sv

// ==== Makefile ====
TOP := tb_event_capture

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

# exit status of the simulation binary is the pass or fail result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
